// ==== logic/front_end_pkg.sv ====
package front_end_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013; // addi x0, x0, 0.

    // Link registers used for return-stack hints.
    localparam logic [reg_addr_w-1:0] link_ra = 5'd1;
    localparam logic [reg_addr_w-1:0] link_t0 = 5'd5;

    localparam logic [6:0] opcode_lui = 7'b0110111;
    localparam logic [6:0] opcode_auipc = 7'b0010111;
    localparam logic [6:0] opcode_jal = 7'b1101111;
    localparam logic [6:0] opcode_jalr = 7'b1100111;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_load = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_op = 7'b0110011;
    localparam logic [6:0] opcode_fence = 7'b0001111;
    localparam logic [6:0] opcode_system = 7'b1110011;

    localparam logic [xlen-1:0] instr_ecall = 32'h0000_0073;
    localparam logic [xlen-1:0] instr_ebreak = 32'h0010_0073;

    typedef enum logic [3:0] {
        op_none,
        op_alu,
        op_alu_imm,
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_branch,
        op_load,
        op_store,
        op_fence,
        op_system
    } op_class_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // Machine cause codes.
    typedef enum logic [3:0] {
        cause_illegal = 4'd2,
        cause_breakpoint = 4'd3,
        cause_ecall_m = 4'd11
    } cause_t;

    typedef struct packed {
        logic valid;
        op_class_t op_class;
        alu_op_t alu_op;
        logic wren;
        logic rden1;
        logic rden2;
        logic [reg_addr_w-1:0] waddr;
        logic [reg_addr_w-1:0] raddr1;
        logic [reg_addr_w-1:0] raddr2;
        logic [xlen-1:0] imm;
        logic ecall;
        logic ebreak;
    } decoder_out_t;

    typedef struct packed {
        logic valid; // Real instruction.
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;
        logic [xlen-1:0] instr;
        op_class_t op_class;
        alu_op_t alu_op;
        logic wren;
        logic rden1;
        logic rden2;
        logic [reg_addr_w-1:0] waddr;
        logic [reg_addr_w-1:0] raddr1;
        logic [reg_addr_w-1:0] raddr2;
        logic [xlen-1:0] imm;
        logic return_push;
        logic return_pop;
        logic jump_uncond;
        logic jump_rest;
        logic exception;
        cause_t ecause;
        logic stall;
    } decode_out_t;

    localparam decode_out_t init_decode_out = '{
        valid: 1'b0,
        pc: reset_pc,
        npc: reset_pc,
        instr: nop_instr,
        op_class: op_none,
        alu_op: alu_add,
        wren: 1'b0,
        rden1: 1'b0,
        rden2: 1'b0,
        waddr: '0,
        raddr1: '0,
        raddr2: '0,
        imm: '0,
        return_push: 1'b0,
        return_pop: 1'b0,
        jump_uncond: 1'b0,
        jump_rest: 1'b0,
        exception: 1'b0,
        ecause: cause_illegal,
        stall: 1'b0
    };

    typedef struct packed {
        logic load; // Instruction in execute is a load.
        logic [reg_addr_w-1:0] waddr;
    } exec_info_t;

    typedef struct packed {
        logic clear;
        logic [xlen-1:0] target;
    } redirect_t;

endpackage

// ==== logic/instr_decoder.sv ====
module instr_decoder (
    input  logic [front_end_pkg::xlen-1:0] instr,
    output front_end_pkg::decoder_out_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [front_end_pkg::xlen-1:0] imm_i;
    logic [front_end_pkg::xlen-1:0] imm_s;
    logic [front_end_pkg::xlen-1:0] imm_b;
    logic [front_end_pkg::xlen-1:0] imm_u;
    logic [front_end_pkg::xlen-1:0] imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Alt selects sub or sra.
    function automatic front_end_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000: alu_sel = alt ? front_end_pkg::alu_sub : front_end_pkg::alu_add;
            3'b001: alu_sel = front_end_pkg::alu_sll;
            3'b010: alu_sel = front_end_pkg::alu_slt;
            3'b011: alu_sel = front_end_pkg::alu_sltu;
            3'b100: alu_sel = front_end_pkg::alu_xor;
            3'b101: alu_sel = alt ? front_end_pkg::alu_sra : front_end_pkg::alu_srl;
            3'b110: alu_sel = front_end_pkg::alu_or;
            default: alu_sel = front_end_pkg::alu_and;
        endcase
    endfunction

    always_comb begin
        dec.valid = 1'b0;
        dec.op_class = front_end_pkg::op_none;
        dec.alu_op = front_end_pkg::alu_add;
        dec.wren = 1'b0;
        dec.rden1 = 1'b0;
        dec.rden2 = 1'b0;
        dec.waddr = instr[11:7];
        dec.raddr1 = instr[19:15];
        dec.raddr2 = instr[24:20];
        dec.imm = '0;
        dec.ecall = 1'b0;
        dec.ebreak = 1'b0;

        if (instr[1:0] == 2'b11) begin // Compressed words stay illegal.
            case (opcode)
                front_end_pkg::opcode_lui: begin
                    dec.valid = 1'b1;
                    dec.op_class = front_end_pkg::op_lui;
                    dec.wren = 1'b1;
                    dec.imm = imm_u;
                end
                front_end_pkg::opcode_auipc: begin
                    dec.valid = 1'b1;
                    dec.op_class = front_end_pkg::op_auipc;
                    dec.wren = 1'b1;
                    dec.imm = imm_u;
                end
                front_end_pkg::opcode_jal: begin
                    dec.valid = 1'b1;
                    dec.op_class = front_end_pkg::op_jal;
                    dec.wren = 1'b1;
                    dec.imm = imm_j;
                end
                front_end_pkg::opcode_jalr: begin
                    dec.valid = (funct3 == 3'b000);
                    dec.op_class = front_end_pkg::op_jalr;
                    dec.wren = 1'b1;
                    dec.rden1 = 1'b1;
                    dec.imm = imm_i;
                end
                front_end_pkg::opcode_branch: begin
                    dec.valid = (funct3 != 3'b010) && (funct3 != 3'b011);
                    dec.op_class = front_end_pkg::op_branch;
                    dec.rden1 = 1'b1;
                    dec.rden2 = 1'b1;
                    dec.imm = imm_b;
                    // Compare through the ALU.
                    if (funct3[2] == 1'b0) begin
                        dec.alu_op = front_end_pkg::alu_sub;
                    end else if (funct3[1] == 1'b0) begin
                        dec.alu_op = front_end_pkg::alu_slt;
                    end else begin
                        dec.alu_op = front_end_pkg::alu_sltu;
                    end
                end
                front_end_pkg::opcode_load: begin
                    dec.valid = (funct3 != 3'b011) && (funct3 != 3'b110) && (funct3 != 3'b111);
                    dec.op_class = front_end_pkg::op_load;
                    dec.wren = 1'b1;
                    dec.rden1 = 1'b1;
                    dec.imm = imm_i;
                end
                front_end_pkg::opcode_store: begin
                    dec.valid = (funct3[2] == 1'b0) && (funct3 != 3'b011);
                    dec.op_class = front_end_pkg::op_store;
                    dec.rden1 = 1'b1;
                    dec.rden2 = 1'b1;
                    dec.imm = imm_s;
                end
                front_end_pkg::opcode_op_imm: begin
                    dec.op_class = front_end_pkg::op_alu_imm;
                    dec.wren = 1'b1;
                    dec.rden1 = 1'b1;
                    dec.imm = imm_i;
                    dec.alu_op = alu_sel(funct3, (funct3 == 3'b101) && instr[30]);
                    if (funct3 == 3'b001) begin
                        dec.valid = (funct7 == 7'b0000000);
                    end else if (funct3 == 3'b101) begin
                        dec.valid = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    end else begin
                        dec.valid = 1'b1;
                    end
                end
                front_end_pkg::opcode_op: begin
                    dec.op_class = front_end_pkg::op_alu;
                    dec.wren = 1'b1;
                    dec.rden1 = 1'b1;
                    dec.rden2 = 1'b1;
                    dec.alu_op = alu_sel(funct3, instr[30]);
                    dec.valid = (funct7 == 7'b0000000) ||
                                ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
                end
                front_end_pkg::opcode_fence: begin
                    dec.valid = (funct3 == 3'b000);
                    dec.op_class = front_end_pkg::op_fence;
                end
                front_end_pkg::opcode_system: begin
                    dec.op_class = front_end_pkg::op_system;
                    dec.ecall = (instr == front_end_pkg::instr_ecall);
                    dec.ebreak = (instr == front_end_pkg::instr_ebreak);
                    dec.valid = dec.ecall || dec.ebreak; // No CSR access here.
                end
                default: begin
                    dec.valid = 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== logic/fetch_stage.sv ====
module fetch_stage (
    input  logic clock,
    input  logic reset,
    input  front_end_pkg::redirect_t redirect,
    input  logic imem_ready,
    input  logic stall,
    output logic [front_end_pkg::xlen-1:0] imem_addr,
    output logic imem_req
);

    logic [front_end_pkg::xlen-1:0] pc;
    logic [front_end_pkg::xlen-1:0] pc_in;
    logic advance;

    // A word leaves fetch only when memory answers and decode takes it.
    assign advance = imem_ready && !stall;

    always_comb begin
        pc_in = pc;
        if (redirect.clear) begin
            pc_in = redirect.target; // Flush wins over everything.
        end else if (advance) begin
            pc_in = pc + 32'd4;
        end
    end

    always_ff @(posedge clock) begin
        if (reset == 1'b0) begin
            pc <= front_end_pkg::reset_pc;
            imem_req <= 1'b0;
        end else begin
            pc <= pc_in;
            imem_req <= 1'b1;
        end
    end

    assign imem_addr = pc;

endmodule

// ==== logic/decode_stage.sv ====
module decode_stage (
    input  logic clock,
    input  logic reset,
    input  logic imem_ready,
    input  logic [front_end_pkg::xlen-1:0] imem_rdata,
    input  logic [front_end_pkg::xlen-1:0] pc,
    input  front_end_pkg::redirect_t redirect,
    input  front_end_pkg::exec_info_t exec,
    output logic [front_end_pkg::xlen-1:0] dec_instr,
    input  front_end_pkg::decoder_out_t dec,
    output logic stall,
    output front_end_pkg::decode_out_t decoded
);

    front_end_pkg::decode_out_t r;
    front_end_pkg::decode_out_t v;
    logic busy;
    logic busy_in;
    logic link_waddr;
    logic link_raddr1;
    logic load_use;

    always_comb begin
        v = r;
        busy_in = busy;
        v.pc = pc;

        // Word select. A pending flush drops the next answer.
        if (imem_ready) begin
            v.instr = imem_rdata;
            v.stall = 1'b0;
            if (busy) begin
                v.instr = front_end_pkg::nop_instr;
                v.stall = 1'b1;
                busy_in = 1'b0;
            end
        end else begin
            v.instr = front_end_pkg::nop_instr;
            v.stall = 1'b1;
            busy_in = busy || redirect.clear;
        end

        dec_instr = v.instr;

        v.valid = dec.valid && !dec.ebreak && !dec.ecall; // Traps are not real instructions.
        v.op_class = dec.op_class;
        v.alu_op = dec.alu_op;
        v.wren = dec.wren;
        v.rden1 = dec.rden1;
        v.rden2 = dec.rden2;
        v.waddr = dec.waddr;
        v.raddr1 = dec.raddr1;
        v.raddr2 = dec.raddr2;
        v.imm = dec.imm;
        v.npc = pc + 32'd4;

        link_waddr = (v.waddr == front_end_pkg::link_ra) || (v.waddr == front_end_pkg::link_t0);
        link_raddr1 = (v.raddr1 == front_end_pkg::link_ra) || (v.raddr1 == front_end_pkg::link_t0);

        v.return_push = 1'b0;
        v.return_pop = 1'b0;
        v.jump_uncond = 1'b0;
        v.jump_rest = 1'b0;

        if (v.op_class == front_end_pkg::op_jal) begin
            if (link_waddr) begin
                v.return_push = 1'b1; // Call.
            end else if (v.waddr == '0) begin
                v.jump_uncond = 1'b1;
            end else begin
                v.jump_rest = 1'b1;
            end
        end

        if (v.op_class == front_end_pkg::op_jalr) begin
            if (!link_waddr && link_raddr1) begin
                v.return_pop = 1'b1; // Return.
            end else if (link_waddr && !link_raddr1) begin
                v.return_push = 1'b1;
            end else if (link_waddr && link_raddr1) begin
                v.return_push = 1'b1;
                v.return_pop = (v.waddr != v.raddr1); // Coroutine swap.
            end else begin
                v.jump_rest = 1'b1;
            end
        end

        v.exception = 1'b0;
        v.ecause = front_end_pkg::cause_illegal;
        if (!dec.valid) begin
            v.exception = 1'b1;
        end else if (dec.ebreak) begin
            v.exception = 1'b1;
            v.ecause = front_end_pkg::cause_breakpoint;
        end else if (dec.ecall) begin
            v.exception = 1'b1;
            v.ecause = front_end_pkg::cause_ecall_m;
        end

        // Loaded value is not ready until the load leaves execute.
        load_use = exec.load &&
                   ((v.rden1 && v.raddr1 == exec.waddr) || (v.rden2 && v.raddr2 == exec.waddr));
        if (load_use) begin
            v.stall = 1'b1;
        end

        if (v.stall || redirect.clear) begin
            v.valid = 1'b0;
            v.op_class = front_end_pkg::op_none;
            v.wren = 1'b0;
            v.rden1 = 1'b0;
            v.rden2 = 1'b0;
            v.return_push = 1'b0;
            v.return_pop = 1'b0;
            v.jump_uncond = 1'b0;
            v.jump_rest = 1'b0;
            v.exception = 1'b0;
        end

        if (redirect.clear) begin
            v.stall = 1'b0; // Let fetch load the target.
        end

        stall = v.stall;
    end

    always_ff @(posedge clock) begin
        if (reset == 1'b0) begin
            r <= front_end_pkg::init_decode_out;
            busy <= 1'b0;
        end else begin
            r <= v;
            busy <= busy_in;
        end
    end

    assign decoded = r;

endmodule

// ==== logic/front_end.sv ====
module front_end (
    input  logic clock,
    input  logic reset,
    input  logic imem_ready,
    input  logic [front_end_pkg::xlen-1:0] imem_rdata,
    input  front_end_pkg::redirect_t redirect,
    input  front_end_pkg::exec_info_t exec,
    output logic [front_end_pkg::xlen-1:0] imem_addr,
    output logic imem_req,
    output front_end_pkg::decode_out_t decoded
);

    logic stall;
    logic [front_end_pkg::xlen-1:0] dec_instr;
    front_end_pkg::decoder_out_t dec;

    fetch_stage fetch0 (
        .clock(clock),
        .reset(reset),
        .redirect(redirect),
        .imem_ready(imem_ready),
        .stall(stall),
        .imem_addr(imem_addr),
        .imem_req(imem_req)
    );

    instr_decoder decoder0 (
        .instr(dec_instr),
        .dec(dec)
    );

    // Decode sees the address of the word memory is answering.
    decode_stage decode0 (
        .clock(clock),
        .reset(reset),
        .imem_ready(imem_ready),
        .imem_rdata(imem_rdata),
        .pc(imem_addr),
        .redirect(redirect),
        .exec(exec),
        .dec_instr(dec_instr),
        .dec(dec),
        .stall(stall),
        .decoded(decoded)
    );

endmodule

// ==== bench/front_end_tb.sv ====
module front_end_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int table_size = 32;
    localparam int hazard_idx = 20;
    localparam int hazard_hold = 6;
    localparam int r1_idx = 21; // Redirect while memory is ready.
    localparam int t1_idx = 24;
    localparam int r2_idx = 26; // Redirect while memory is not ready.
    localparam int t2_idx = 28;
    localparam int cycle_limit = 2000;

    typedef struct packed {
        logic [31:0] instr;
        logic valid;
        front_end_pkg::op_class_t op_class;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [31:0] imm;
        logic [3:0] hints; // Push, pop, uncond, rest.
        logic exception;
        front_end_pkg::cause_t cause;
    } entry_t;

    logic clock;
    logic reset;
    logic imem_ready;
    logic [31:0] imem_rdata;
    front_end_pkg::redirect_t redirect;
    front_end_pkg::exec_info_t exec;
    logic [31:0] imem_addr;
    logic imem_req;
    front_end_pkg::decode_out_t decoded;

    entry_t tbl [table_size];
    int tbl_count;
    int exp_q [$];
    logic [31:0] rnd;
    int hazard_state; // 0 before, 1 held, 2 released.
    int hold_left;
    logic r1_done;
    logic r2_done;
    logic stale_pending;
    int check_count;
    int mismatch_count;
    int error_count;

    front_end dut0 (
        .clock(clock),
        .reset(reset),
        .imem_ready(imem_ready),
        .imem_rdata(imem_rdata),
        .redirect(redirect),
        .exec(exec),
        .imem_addr(imem_addr),
        .imem_req(imem_req),
        .decoded(decoded)
    );

    always #50 clock = ~clock;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, front_end_pkg::opcode_op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], front_end_pkg::opcode_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11],
                front_end_pkg::opcode_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, front_end_pkg::opcode_jal};
    endfunction

    function automatic logic writes_rd(input front_end_pkg::op_class_t op);
        return op inside {front_end_pkg::op_alu, front_end_pkg::op_alu_imm,
                          front_end_pkg::op_lui, front_end_pkg::op_auipc,
                          front_end_pkg::op_jal, front_end_pkg::op_jalr,
                          front_end_pkg::op_load};
    endfunction

    function automatic logic reads_rs1(input front_end_pkg::op_class_t op);
        return op inside {front_end_pkg::op_alu, front_end_pkg::op_alu_imm,
                          front_end_pkg::op_jalr, front_end_pkg::op_branch,
                          front_end_pkg::op_load, front_end_pkg::op_store};
    endfunction

    function automatic logic reads_rs2(input front_end_pkg::op_class_t op);
        return op inside {front_end_pkg::op_alu, front_end_pkg::op_branch,
                          front_end_pkg::op_store};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr < 32'(tbl_count * 4)) begin
            return tbl[addr[6:2]].instr;
        end
        return front_end_pkg::nop_instr; // Past the program.
    endfunction

    task automatic add_op(input logic [31:0] instr, input front_end_pkg::op_class_t op,
                          input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                          input logic [31:0] imm);
        tbl[tbl_count] = '{instr, 1'b1, op, rd, rs1, rs2, imm, 4'b0000, 1'b0,
                           front_end_pkg::cause_illegal};
        tbl_count++;
    endtask

    task automatic add_jump(input logic [31:0] instr, input front_end_pkg::op_class_t op,
                            input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [31:0] imm, input logic [3:0] hints);
        tbl[tbl_count] = '{instr, 1'b1, op, rd, rs1, 5'd0, imm, hints, 1'b0,
                           front_end_pkg::cause_illegal};
        tbl_count++;
    endtask

    task automatic add_trap(input logic [31:0] instr, input front_end_pkg::op_class_t op,
                            input front_end_pkg::cause_t cause);
        tbl[tbl_count] = '{instr, 1'b0, op, 5'd0, 5'd0, 5'd0, 32'd0, 4'b0000, 1'b1, cause};
        tbl_count++;
    endtask

    task automatic build_table();
        add_op(i_type(12'd5, 5'd0, 3'b000, 5'd3, front_end_pkg::opcode_op_imm),
               front_end_pkg::op_alu_imm, 5'd3, 5'd0, 5'd0, 32'd5);
        add_op(r_type(7'h20, 5'd2, 5'd3, 3'b000, 5'd4), front_end_pkg::op_alu,
               5'd4, 5'd3, 5'd2, 32'd0);
        add_op(i_type(12'hff8, 5'd4, 3'b010, 5'd6, front_end_pkg::opcode_load),
               front_end_pkg::op_load, 5'd6, 5'd4, 5'd0, 32'hffff_fff8);
        add_op(s_type(12'd12, 5'd6, 5'd4, 3'b010), front_end_pkg::op_store,
               5'd0, 5'd4, 5'd6, 32'd12);
        add_op(b_type(13'h1ff0, 5'd4, 5'd3, 3'b000), front_end_pkg::op_branch,
               5'd0, 5'd3, 5'd4, 32'hffff_fff0);
        add_op(u_type(20'h12345, 5'd7, front_end_pkg::opcode_lui), front_end_pkg::op_lui,
               5'd7, 5'd0, 5'd0, 32'h1234_5000);
        add_op(u_type(20'hfffff, 5'd8, front_end_pkg::opcode_auipc), front_end_pkg::op_auipc,
               5'd8, 5'd0, 5'd0, 32'hffff_f000);
        add_op(i_type(12'h403, 5'd7, 3'b101, 5'd9, front_end_pkg::opcode_op_imm),
               front_end_pkg::op_alu_imm, 5'd9, 5'd7, 5'd0, 32'h0000_0403); // srai
        add_jump(j_type(21'h000800, 5'd1), front_end_pkg::op_jal, 5'd1, 5'd0,
                 32'h0000_0800, 4'b1000);
        add_jump(j_type(21'h1ffffc, 5'd0), front_end_pkg::op_jal, 5'd0, 5'd0,
                 32'hffff_fffc, 4'b0010);
        add_jump(j_type(21'd16, 5'd6), front_end_pkg::op_jal, 5'd6, 5'd0, 32'd16, 4'b0001);
        add_jump(i_type(12'd0, 5'd1, 3'b000, 5'd0, front_end_pkg::opcode_jalr),
                 front_end_pkg::op_jalr, 5'd0, 5'd1, 32'd0, 4'b0100);
        add_jump(i_type(12'd4, 5'd6, 3'b000, 5'd1, front_end_pkg::opcode_jalr),
                 front_end_pkg::op_jalr, 5'd1, 5'd6, 32'd4, 4'b1000);
        add_jump(i_type(12'd0, 5'd5, 3'b000, 5'd1, front_end_pkg::opcode_jalr),
                 front_end_pkg::op_jalr, 5'd1, 5'd5, 32'd0, 4'b1100);
        add_jump(i_type(12'd0, 5'd5, 3'b000, 5'd5, front_end_pkg::opcode_jalr),
                 front_end_pkg::op_jalr, 5'd5, 5'd5, 32'd0, 4'b1000);
        add_jump(i_type(12'd0, 5'd6, 3'b000, 5'd6, front_end_pkg::opcode_jalr),
                 front_end_pkg::op_jalr, 5'd6, 5'd6, 32'd0, 4'b0001);
        add_trap(32'h0000_0000, front_end_pkg::op_none, front_end_pkg::cause_illegal);
        add_trap(32'h0000_4501, front_end_pkg::op_none, front_end_pkg::cause_illegal);
        add_trap(32'h0010_0073, front_end_pkg::op_system, front_end_pkg::cause_breakpoint);
        add_trap(32'h0000_0073, front_end_pkg::op_system, front_end_pkg::cause_ecall_m);
        add_op(r_type(7'h00, 5'd11, 5'd7, 3'b000, 5'd10), front_end_pkg::op_alu,
               5'd10, 5'd7, 5'd11, 32'd0); // Load-use victim.
        add_op(r_type(7'h00, 5'd3, 5'd10, 3'b110, 5'd12), front_end_pkg::op_alu,
               5'd12, 5'd10, 5'd3, 32'd0);
        add_op(r_type(7'h00, 5'd4, 5'd12, 3'b100, 5'd13), front_end_pkg::op_alu,
               5'd13, 5'd12, 5'd4, 32'd0);
        add_op(i_type(12'd1, 5'd13, 3'b001, 5'd13, front_end_pkg::opcode_op_imm),
               front_end_pkg::op_alu_imm, 5'd13, 5'd13, 5'd0, 32'd1);
        add_op(i_type(12'hfff, 5'd12, 3'b010, 5'd14, front_end_pkg::opcode_op_imm),
               front_end_pkg::op_alu_imm, 5'd14, 5'd12, 5'd0, 32'hffff_ffff);
        add_op(i_type(12'h0ff, 5'd14, 3'b111, 5'd15, front_end_pkg::opcode_op_imm),
               front_end_pkg::op_alu_imm, 5'd15, 5'd14, 5'd0, 32'h0000_00ff);
        add_op(b_type(13'd8, 5'd0, 5'd15, 3'b001), front_end_pkg::op_branch,
               5'd0, 5'd15, 5'd0, 32'd8);
        add_op(r_type(7'h00, 5'd14, 5'd15, 3'b011, 5'd16), front_end_pkg::op_alu,
               5'd16, 5'd15, 5'd14, 32'd0);
        add_op(i_type(12'd1, 5'd0, 3'b110, 5'd16, front_end_pkg::opcode_op_imm),
               front_end_pkg::op_alu_imm, 5'd16, 5'd0, 5'd0, 32'd1);
        add_op(r_type(7'h00, 5'd16, 5'd16, 3'b001, 5'd17), front_end_pkg::op_alu,
               5'd17, 5'd16, 5'd16, 32'd0);
        add_op(s_type(12'd2, 5'd17, 5'd0, 3'b001), front_end_pkg::op_store,
               5'd0, 5'd0, 5'd17, 32'd2);
        add_op(i_type(12'd1, 5'd17, 3'b100, 5'd18, front_end_pkg::opcode_load),
               front_end_pkg::op_load, 5'd18, 5'd17, 5'd0, 32'd1);
    endtask

    task automatic compare(input int idx, input string what, input logic [31:0] got,
                           input logic [31:0] want);
        check_count++;
        assert (got === want) else begin
            mismatch_count++;
            $display("Mismatch at %0t ns: entry %0d %s is %h, expected %h",
                     $time, idx, what, got, want);
        end
    endtask

    task automatic check_entry(input int idx);
        entry_t e;
        logic [3:0] hints;
        e = tbl[idx];
        hints = {decoded.return_push, decoded.return_pop, decoded.jump_uncond,
                 decoded.jump_rest};
        compare(idx, "pc", decoded.pc, 32'(idx * 4));
        compare(idx, "npc", decoded.npc, 32'(idx * 4 + 4));
        compare(idx, "instr", decoded.instr, e.instr);
        compare(idx, "valid", 32'(decoded.valid), 32'(e.valid));
        compare(idx, "exception", 32'(decoded.exception), 32'(e.exception));
        compare(idx, "op_class", 32'(decoded.op_class), 32'(e.op_class));
        if (e.exception) begin
            compare(idx, "ecause", 32'(decoded.ecause), 32'(e.cause));
        end
        if (e.valid) begin
            compare(idx, "hints", 32'(hints), 32'(e.hints));
            compare(idx, "imm", decoded.imm, e.imm);
            compare(idx, "wren", 32'(decoded.wren), 32'(writes_rd(e.op_class)));
            compare(idx, "rden1", 32'(decoded.rden1), 32'(reads_rs1(e.op_class)));
            compare(idx, "rden2", 32'(decoded.rden2), 32'(reads_rs2(e.op_class)));
            if (writes_rd(e.op_class)) begin
                compare(idx, "waddr", 32'(decoded.waddr), 32'(e.rd));
            end
            if (reads_rs1(e.op_class)) begin
                compare(idx, "raddr1", 32'(decoded.raddr1), 32'(e.rs1));
            end
            if (reads_rs2(e.op_class)) begin
                compare(idx, "raddr2", 32'(decoded.raddr2), 32'(e.rs2));
            end
        end
        if (idx == hazard_idx) begin
            assert (hazard_state == 2) else begin
                error_count++;
                $display("Entry %0d came out at %0t ns while its load-use hazard was held",
                         idx, $time);
            end
        end
    endtask

    task automatic drive_cycle();
        rnd = next_random(rnd);
        imem_ready = (rnd[1:0] != 2'b00); // Ready about three cycles in four.
        redirect = '0;
        if (hazard_state == 0 && imem_addr == 32'(hazard_idx * 4)) begin
            hazard_state = 1;
            hold_left = hazard_hold;
            exec.load = 1'b1;
            exec.waddr = tbl[hazard_idx].rs1;
        end else if (hazard_state == 1) begin
            hold_left--;
            if (hold_left == 0) begin
                exec = '0;
                hazard_state = 2;
            end
        end
        if (!r1_done && imem_addr == 32'(r1_idx * 4)) begin
            r1_done = 1'b1;
            imem_ready = 1'b1;
            redirect.clear = 1'b1;
            redirect.target = 32'(t1_idx * 4);
        end else if (!r2_done && imem_addr == 32'(r2_idx * 4)) begin
            r2_done = 1'b1;
            stale_pending = 1'b1;
            imem_ready = 1'b0; // Leaves an outstanding request behind.
            redirect.clear = 1'b1;
            redirect.target = 32'(t2_idx * 4);
        end
        if (stale_pending && imem_ready) begin
            imem_rdata = fetch_word(32'(r2_idx * 4)); // Late answer from the old path.
            stale_pending = 1'b0;
        end else begin
            imem_rdata = fetch_word(imem_addr);
        end
    endtask

    initial begin
        int idx;
        int cycle;
        clock = 1'b0;
        reset = 1'b0;
        imem_ready = 1'b0;
        imem_rdata = '0;
        redirect = '0;
        exec = '0;
        rnd = 32'h9d3a_e4f0;
        tbl_count = 0;
        hazard_state = 0;
        hold_left = 0;
        r1_done = 1'b0;
        r2_done = 1'b0;
        stale_pending = 1'b0;
        check_count = 0;
        mismatch_count = 0;
        error_count = 0;
        build_table();

        // Path through the program once both redirects have skipped their gaps.
        for (int i = 0; i < tbl_count; i++) begin
            if (!((i >= r1_idx && i < t1_idx) || (i >= r2_idx && i < t2_idx))) begin
                exp_q.push_back(i);
            end
        end

        repeat (10) @(posedge clock);
        @(negedge clock);
        assert (imem_req === 1'b0 && decoded.valid === 1'b0) else begin
            error_count++;
            $display("imem_req or decoded.valid was high during reset");
        end
        reset = 1'b1;

        cycle = 0;
        while (exp_q.size() > 0 && cycle < cycle_limit) begin
            @(negedge clock);
            cycle++;
            assert (imem_req === 1'b1) else begin
                error_count++;
                $display("imem_req was low at %0t ns after reset was released", $time);
            end
            if (hazard_state == 1) begin
                compare(hazard_idx, "stall while hazard held", 32'(decoded.stall), 32'd1);
            end
            if (decoded.valid || decoded.exception) begin
                idx = exp_q.pop_front();
                check_entry(idx);
            end
            drive_cycle();
        end
        if (exp_q.size() > 0) begin
            error_count++;
            $display("Timeout after %0d cycles with %0d expected entries never decoded",
                     cycle, exp_q.size());
        end

        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
logic/front_end_pkg.sv
logic/instr_decoder.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/front_end.sv
bench/front_end_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the front end testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module front_end_tb -Mdir obj_dir -o front_end_sim -f src.f > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/front_end_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "No result line found in sim.log"
    exit 1
fi
exit 0
